// ==== hw/mem_sys_pkg.sv ====
// Shared widths, credit/latency constants, memory opcode enum and port tag type
package mem_sys_pkg;

    // Datapath and addressing
    localparam int data_w = 16;             // Data and byte address width
    localparam int mem_aw = 10;             // Word address bits, 1024 words
    localparam int reg_aw = 4;              // Register number width

    // Arbiter queue and credits
    localparam int num_ports   = 2;                         // Data stage and fetch
    localparam int mem_credits = 2;                         // Queue depth per port
    localparam int credit_w    = $clog2(mem_credits + 1);   // Counter holds 0..mem_credits
    localparam int cq_aw       = $clog2(mem_credits);       // Queue pointer width

    // Memory read pipeline
    localparam int mem_latency = 4;         // Accepted read to rd_valid

    // Instruction queue
    localparam int fetch_queue_depth = 4;
    localparam int fq_aw = $clog2(fetch_queue_depth);       // Slot pointer
    localparam int fq_cw = $clog2(fetch_queue_depth + 1);   // Occupancy count

    // Stack pointer adjust on call and return, in bytes
    localparam int stack_step = 2;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    // Tags a request and its response with the requester
    typedef enum logic {
        port_data  = 1'b0,
        port_fetch = 1'b1
    } port_e;

endpackage

// ==== hw/mem_req_if.sv ====
// Requester to arbiter link: request, credit return and response, with both modports
`timescale 1ns/100ps

interface mem_req_if import mem_sys_pkg::*; ();

    // Request side, one cycle per request
    logic              req_valid;
    mem_op_e           req_op;
    logic [data_w-1:0] req_addr;     // Byte address
    logic [data_w-1:0] req_wdata;

    logic              credit_ret;   // Queue slot freed

    // Read response, no back-pressure
    logic              rsp_valid;
    logic [data_w-1:0] rsp_rdata;

    modport requester (
        output req_valid,
        output req_op,
        output req_addr,
        output req_wdata,
        input  credit_ret,
        input  rsp_valid,
        input  rsp_rdata
    );

    modport arbiter (
        input  req_valid,
        input  req_op,
        input  req_addr,
        input  req_wdata,
        output credit_ret,
        output rsp_valid,
        output rsp_rdata
    );

endinterface

// ==== hw/mem_stage.sv ====
// Data memory stage: call/return stack adjust, load/store issue, credit counter, writeback register
`timescale 1ns/100ps

module mem_stage import mem_sys_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,

    // From execute
    input  logic              ex_valid,
    output logic              ex_ready,
    input  logic              call,
    input  logic              ret_future,
    input  logic              reg_write,
    input  logic              mem_write,
    input  logic              mem_read,
    input  logic              mem_to_reg,    // Load result goes to register
    input  logic [reg_aw-1:0] reg_rd,        // Destination register
    input  logic [data_w-1:0] alu_result,
    input  logic [data_w-1:0] store_data,    // PC during call

    // To writeback
    output logic              wb_valid,
    output logic              wb_reg_write,
    output logic              wb_ret_future,
    output logic              wb_mem_to_reg,
    output logic [reg_aw-1:0] wb_reg_rd,
    output logic [data_w-1:0] wb_mem_read_data,
    output logic [data_w-1:0] wb_alu_result,

    mem_req_if.requester      bus
);

    logic [data_w-1:0]   alu_fwd;       // Stack adjusted result
    logic [data_w-1:0]   mem_addr;
    logic                is_mem;
    logic                accept;
    logic                issue;
    logic                pend;          // Mem op waiting for a credit
    logic                wait_rsp;      // Load sent, response not yet back
    logic                rsp_take;
    mem_op_e             op_q;
    logic [data_w-1:0]   addr_q;
    logic [data_w-1:0]   wdata_q;
    logic [credit_w-1:0] credit_cnt;

    // SP moves down on call
    assign alu_fwd  = call ? alu_result - data_w'(stack_step) : alu_result;
    // Return address sits one step above SP
    assign mem_addr = ret_future ? alu_result + data_w'(stack_step) : alu_result;

    assign is_mem   = mem_write || mem_read;
    assign ex_ready = !pend && !wait_rsp;    // One op in flight at a time
    assign accept   = ex_valid && ex_ready;
    assign issue    = pend && (credit_cnt != '0);
    assign rsp_take = wait_rsp && bus.rsp_valid;

    // Request driven straight from the held op
    assign bus.req_valid = issue;
    assign bus.req_op    = op_q;
    assign bus.req_addr  = addr_q;
    assign bus.req_wdata = wdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend       <= 1'b0;
            wait_rsp   <= 1'b0;
            wb_valid   <= 1'b0;
            credit_cnt <= credit_w'(mem_credits);
        end else begin
            wb_valid   <= 1'b0;    // Single cycle pulse
            credit_cnt <= credit_cnt - credit_w'(issue) + credit_w'(bus.credit_ret);

            // Non-memory ops retire next cycle
            if (accept) begin
                pend     <= is_mem;
                wb_valid <= !is_mem;
            end

            // Store is posted, load waits for data
            if (issue) begin
                pend     <= 1'b0;
                wait_rsp <= (op_q == op_read);
                wb_valid <= (op_q == op_write);
            end

            if (rsp_take) begin
                wait_rsp <= 1'b0;
                wb_valid <= 1'b1;
            end
        end
    end

    // Writeback fields held while the op waits
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_reg_write  <= reg_write;
            wb_ret_future <= ret_future;
            wb_mem_to_reg <= mem_to_reg;
            wb_reg_rd     <= reg_rd;
            wb_alu_result <= alu_fwd;
            op_q          <= mem_write ? op_write : op_read;   // Write wins if both set
            addr_q        <= mem_addr;
            wdata_q       <= store_data;
        end
        if (rsp_take)
            wb_mem_read_data <= bus.rsp_rdata;
    end

endmodule

// ==== hw/fetch_unit.sv ====
// Sequential instruction fetch: PC, credit counter, outstanding reads and instruction queue
`timescale 1ns/100ps

module fetch_unit import mem_sys_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              fetch_en,
    input  logic              pc_load,
    input  logic [data_w-1:0] pc_load_value,
    output logic              instr_valid,
    output logic [data_w-1:0] instr,
    output logic [data_w-1:0] instr_pc,
    input  logic              instr_ready,
    mem_req_if.requester      bus
);

    logic [data_w-1:0]   pc;
    logic [credit_w-1:0] credit_cnt;
    logic [fq_cw-1:0]    outstanding;   // Reads sent, no data yet
    logic [fq_cw-1:0]    q_count;       // Filled slots
    logic [fq_aw-1:0]    iss_ptr;       // Slot reserved by next read
    logic [fq_aw-1:0]    fill_ptr;      // Slot for next response
    logic [fq_aw-1:0]    rd_ptr;        // Queue head
    logic [data_w-1:0]   q_pc    [fetch_queue_depth];
    logic [data_w-1:0]   q_instr [fetch_queue_depth];
    logic                issue;
    logic                pop;

    // Slot reserved per read so a response always has a home
    assign issue = fetch_en && (credit_cnt != '0)
                && ((q_count + outstanding) < fq_cw'(fetch_queue_depth));
    assign pop   = instr_valid && instr_ready;

    assign bus.req_valid = issue;
    assign bus.req_op    = op_read;
    assign bus.req_addr  = pc;
    assign bus.req_wdata = '0;    // Fetch never writes

    assign instr_valid = (q_count != '0);
    assign instr       = q_instr[rd_ptr];
    assign instr_pc    = q_pc[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= '0;
            credit_cnt  <= credit_w'(mem_credits);
            outstanding <= '0;
            q_count     <= '0;
            iss_ptr     <= '0;
            fill_ptr    <= '0;
            rd_ptr      <= '0;
        end else begin
            if (!fetch_en && pc_load)
                pc <= pc_load_value;
            else if (issue)
                pc <= pc + data_w'(2);    // Next word
            credit_cnt  <= credit_cnt - credit_w'(issue) + credit_w'(bus.credit_ret);
            outstanding <= outstanding + fq_cw'(issue) - fq_cw'(bus.rsp_valid);
            q_count     <= q_count + fq_cw'(bus.rsp_valid) - fq_cw'(pop);
            iss_ptr     <= iss_ptr + fq_aw'(issue);    // Depth is a power of two
            fill_ptr    <= fill_ptr + fq_aw'(bus.rsp_valid);
            rd_ptr      <= rd_ptr + fq_aw'(pop);
        end
    end

    // PC logged at issue, data paired on in-order return
    always_ff @(posedge clk) begin
        if (issue)
            q_pc[iss_ptr] <= pc;
        if (bus.rsp_valid)
            q_instr[fill_ptr] <= bus.rsp_rdata;
    end

endmodule

// ==== hw/mem_arbiter.sv ====
// Per-port request queues, round-robin grant to memory, credit return, response routing
`timescale 1ns/100ps

module mem_arbiter import mem_sys_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    mem_req_if.arbiter        data_bus,
    mem_req_if.arbiter        fetch_bus,

    // To memory
    output logic              mem_valid,
    output mem_op_e           mem_op,
    output logic [data_w-1:0] mem_addr,
    output logic [data_w-1:0] mem_wdata,
    output port_e             mem_port,

    // From memory
    input  logic              rd_valid,
    input  port_e             rd_port,
    input  logic [data_w-1:0] rd_data
);

    logic [num_ports-1:0] push;
    mem_op_e              push_op    [num_ports];
    logic [data_w-1:0]    push_addr  [num_ports];
    logic [data_w-1:0]    push_wdata [num_ports];
    mem_op_e              q_op       [num_ports][mem_credits];
    logic [data_w-1:0]    q_addr     [num_ports][mem_credits];
    logic [data_w-1:0]    q_wdata    [num_ports][mem_credits];
    logic [cq_aw-1:0]     wr_ptr     [num_ports];
    logic [cq_aw-1:0]     rd_ptr     [num_ports];
    logic [credit_w-1:0]  q_count    [num_ports];   // Never above mem_credits
    logic [num_ports-1:0] head_v;
    logic [num_ports-1:0] pop;
    logic                 gnt_valid;
    port_e                gnt_port;
    port_e                rr_last;                  // Last port granted
    logic [num_ports-1:0] rsp_v;
    logic [data_w-1:0]    rsp_data;

    // Links into port-indexed arrays
    always_comb begin
        push[port_data]        = data_bus.req_valid;
        push_op[port_data]     = data_bus.req_op;
        push_addr[port_data]   = data_bus.req_addr;
        push_wdata[port_data]  = data_bus.req_wdata;
        push[port_fetch]       = fetch_bus.req_valid;
        push_op[port_fetch]    = fetch_bus.req_op;
        push_addr[port_fetch]  = fetch_bus.req_addr;
        push_wdata[port_fetch] = fetch_bus.req_wdata;
    end

    // Round robin only matters when both heads wait
    always_comb begin
        for (int p = 0; p < num_ports; p++)
            head_v[p] = (q_count[p] != '0);
        gnt_valid = |head_v;
        if (&head_v)
            gnt_port = (rr_last == port_data) ? port_fetch : port_data;
        else if (head_v[port_fetch])
            gnt_port = port_fetch;
        else
            gnt_port = port_data;
        pop = '0;
        pop[gnt_port] = gnt_valid;
    end

    assign mem_valid = gnt_valid;
    assign mem_op    = q_op[gnt_port][rd_ptr[gnt_port]];
    assign mem_addr  = q_addr[gnt_port][rd_ptr[gnt_port]];
    assign mem_wdata = q_wdata[gnt_port][rd_ptr[gnt_port]];
    assign mem_port  = gnt_port;

    // Slot freed in the grant cycle
    assign data_bus.credit_ret  = pop[port_data];
    assign fetch_bus.credit_ret = pop[port_fetch];

    assign data_bus.rsp_valid  = rsp_v[port_data];
    assign data_bus.rsp_rdata  = rsp_data;
    assign fetch_bus.rsp_valid = rsp_v[port_fetch];
    assign fetch_bus.rsp_rdata = rsp_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < num_ports; p++) begin
                wr_ptr[p]  <= '0;
                rd_ptr[p]  <= '0;
                q_count[p] <= '0;
            end
            rr_last <= port_fetch;    // Data goes first on a tie
            rsp_v   <= '0;
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                wr_ptr[p]  <= wr_ptr[p] + cq_aw'(push[p]);
                rd_ptr[p]  <= rd_ptr[p] + cq_aw'(pop[p]);
                q_count[p] <= q_count[p] + credit_w'(push[p]) - credit_w'(pop[p]);
            end
            if (gnt_valid)
                rr_last <= gnt_port;
            rsp_v <= '0;
            if (rd_valid)
                rsp_v[rd_port] <= 1'b1;    // Steer by tag
        end
    end

    // Queue payload and response data
    always_ff @(posedge clk) begin
        for (int p = 0; p < num_ports; p++) begin
            if (push[p]) begin
                q_op[p][wr_ptr[p]]    <= push_op[p];
                q_addr[p][wr_ptr[p]]  <= push_addr[p];
                q_wdata[p][wr_ptr[p]] <= push_wdata[p];
            end
        end
        if (rd_valid)
            rsp_data <= rd_data;
    end

endmodule

// ==== hw/unified_mem.sv ====
// Unified word memory with port-tagged fixed latency read pipeline
`timescale 1ns/100ps

module unified_mem import mem_sys_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,

    // Request, one per cycle
    input  logic              mem_valid,
    input  mem_op_e           mem_op,
    input  logic [data_w-1:0] mem_addr,
    input  logic [data_w-1:0] mem_wdata,
    input  port_e             mem_port,

    // Read response
    output logic              rd_valid,
    output port_e             rd_port,
    output logic [data_w-1:0] rd_data
);

    logic [data_w-1:0]      mem_array [2**mem_aw];
    logic [mem_aw-1:0]      word_addr;
    logic                   rd_req;
    logic                   wr_req;
    logic [mem_latency-1:0] vld_pipe;
    port_e                  port_pipe [mem_latency];
    logic [data_w-1:0]      data_pipe [mem_latency];

    // Byte address, bit 0 dropped
    assign word_addr = mem_addr[mem_aw:1];
    assign rd_req    = mem_valid && (mem_op == op_read);
    assign wr_req    = mem_valid && (mem_op == op_write);

    // Valid bits only, data rides alongside
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            vld_pipe <= '0;
        else
            vld_pipe <= {vld_pipe[mem_latency-2:0], rd_req};
    end

    always_ff @(posedge clk) begin
        if (wr_req)
            mem_array[word_addr] <= mem_wdata;    // Visible to next read
        port_pipe[0] <= mem_port;
        data_pipe[0] <= mem_array[word_addr];
        for (int i = 1; i < mem_latency; i++) begin
            port_pipe[i] <= port_pipe[i-1];
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    // Last stage, mem_latency cycles after accept
    assign rd_valid = vld_pipe[mem_latency-1];
    assign rd_port  = port_pipe[mem_latency-1];
    assign rd_data  = data_pipe[mem_latency-1];

endmodule

// ==== hw/mem_sys_top.sv ====
// Memory system top: data stage, fetch unit, arbiter and unified memory wired together
`timescale 1ns/100ps

module mem_sys_top import mem_sys_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,

    // Execute to data stage
    input  logic              ex_valid,
    output logic              ex_ready,
    input  logic              call,
    input  logic              ret_future,
    input  logic              reg_write,
    input  logic              mem_write,
    input  logic              mem_read,
    input  logic              mem_to_reg,
    input  logic [reg_aw-1:0] reg_rd,
    input  logic [data_w-1:0] alu_result,
    input  logic [data_w-1:0] store_data,

    // Writeback
    output logic              wb_valid,
    output logic              wb_reg_write,
    output logic              wb_ret_future,
    output logic              wb_mem_to_reg,
    output logic [reg_aw-1:0] wb_reg_rd,
    output logic [data_w-1:0] wb_mem_read_data,
    output logic [data_w-1:0] wb_alu_result,

    // Fetch
    input  logic              fetch_en,
    input  logic              pc_load,
    input  logic [data_w-1:0] pc_load_value,
    output logic              instr_valid,
    output logic [data_w-1:0] instr,
    output logic [data_w-1:0] instr_pc,
    input  logic              instr_ready
);

    // Arbiter to memory
    logic              mem_valid;
    mem_op_e           mem_op;
    logic [data_w-1:0] mem_addr;
    logic [data_w-1:0] mem_wdata;
    port_e             mem_port;
    logic              rd_valid;
    port_e             rd_port;
    logic [data_w-1:0] rd_data;

    mem_req_if data_link ();
    mem_req_if fetch_link ();

    mem_stage u_mem_stage (
        .clk, .arst_n, .ex_valid, .ex_ready, .call, .ret_future, .reg_write,
        .mem_write, .mem_read, .mem_to_reg, .reg_rd, .alu_result, .store_data,
        .wb_valid, .wb_reg_write, .wb_ret_future, .wb_mem_to_reg, .wb_reg_rd,
        .wb_mem_read_data, .wb_alu_result,
        .bus (data_link.requester)
    );

    fetch_unit u_fetch_unit (
        .clk, .arst_n, .fetch_en, .pc_load, .pc_load_value,
        .instr_valid, .instr, .instr_pc, .instr_ready,
        .bus (fetch_link.requester)
    );

    mem_arbiter u_mem_arbiter (
        .clk, .arst_n,
        .data_bus  (data_link.arbiter),
        .fetch_bus (fetch_link.arbiter),
        .mem_valid, .mem_op, .mem_addr, .mem_wdata, .mem_port,
        .rd_valid, .rd_port, .rd_data
    );

    unified_mem u_unified_mem (
        .clk, .arst_n,
        .mem_valid, .mem_op, .mem_addr, .mem_wdata, .mem_port,
        .rd_valid, .rd_port, .rd_data
    );

endmodule

// ==== verification/mem_sys_checker.sv ====
// Concurrent assertions on arbiter queue credits, grant, read latency and reset, with binds
`timescale 1ns/100ps

module mem_sys_checker import mem_sys_pkg::*; #(
    parameter bit with_queues = 1'b1    // Arbiter side holds the queues
) (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 mem_valid,
    input mem_op_e              mem_op,
    input logic                 rd_valid,
    input logic [credit_w-1:0]  count_data,    // Arbiter queue occupancy per port
    input logic [credit_w-1:0]  count_fetch,
    input logic [num_ports-1:0] push           // Queue writes this cycle
);

    logic rd_accept;

    assign rd_accept = mem_valid && (mem_op == op_read);

    if (with_queues) begin : g_queues
        int level;    // Entries across both queues

        assign level = int'(count_data) + int'(count_fetch);

        // Queue never holds more than the credits handed out
        credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
            (count_data <= credit_w'(mem_credits)) && (count_fetch <= credit_w'(mem_credits)))
            else $error("Arbiter queue holds more entries than credits");

        // One entry leaves the queues per memory request, so one port at most
        one_grant: assert property (@(posedge clk) disable iff (!arst_n)
            ($past(level) + $countones($past(push)) - level) == int'($past(mem_valid)))
            else $error("Queues drained other than one entry per memory request");
    end

    // Fixed latency both ways
    read_latency: assert property (@(posedge clk) disable iff (!arst_n)
        rd_accept |-> ##mem_latency rd_valid)
        else $error("Accepted read gave no rd_valid after the fixed latency");
    no_stray_rsp: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> $past(rd_accept, mem_latency))
        else $error("rd_valid without a read accepted at the fixed latency");

    idle_in_reset: assert property (@(posedge clk) !arst_n |-> !mem_valid)
        else $error("mem_valid high during reset");

endmodule

// Index 0 is the data port, 1 the fetch port
bind mem_arbiter mem_sys_checker arb_check (
    .clk, .arst_n, .mem_valid, .mem_op, .rd_valid,
    .count_data (q_count[0]), .count_fetch (q_count[1]), .push
);

// Memory side has no queues, only latency and reset apply
bind unified_mem mem_sys_checker #(.with_queues (1'b0)) mem_check (
    .clk, .arst_n, .mem_valid, .mem_op, .rd_valid,
    .count_data ('0), .count_fetch ('0), .push ('0)
);

// ==== verification/mem_sys_tb.sv ====
// Testbench for the memory system: clock, reset, random stimulus, reference model and checks
`timescale 1ns/100ps

module mem_sys_tb import mem_sys_pkg::*; ();

    localparam logic [data_w-1:0] region_a = 16'h0200;   // Instruction and first data region
    localparam int                a_words  = 64;
    localparam logic [data_w-1:0] region_b = 16'h0600;   // Data region used during fetch
    localparam int                b_words  = 16;
    localparam int                wait_limit = 200;       // Cycles per wait

    typedef struct {
        logic              reg_write;
        logic              ret_future;
        logic              mem_to_reg;
        logic [reg_aw-1:0] reg_rd;
        logic [data_w-1:0] alu;
        logic              is_load;
        logic [data_w-1:0] rdata;
    } wb_rec_t;

    logic clk, arst_n, ex_valid, ex_ready, call, ret_future, reg_write;
    logic mem_write, mem_read, mem_to_reg, wb_valid, wb_reg_write, wb_ret_future;
    logic wb_mem_to_reg, fetch_en, pc_load, instr_valid, instr_ready;
    logic [reg_aw-1:0] reg_rd, wb_reg_rd;
    logic [data_w-1:0] alu_result, store_data, wb_mem_read_data, wb_alu_result;
    logic [data_w-1:0] pc_load_value, instr, instr_pc;

    logic [data_w-1:0] model_mem [int];   // Word index to last stored value
    wb_rec_t           exp_q [$];         // Expected writeback, issue order
    wb_rec_t           mon_rec;
    logic [data_w-1:0] exp_pc;            // Next instruction address
    int                checks = 0;
    int                errors = 0;

    mem_sys_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic end_run();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        errors++;
        end_run();
    endtask

    task automatic check_val(input string what, input logic [data_w-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Builds the expected record, then holds ex_valid until accepted
    task automatic send_op(input logic c, rf, rw, mw, mr, m2r, input logic [reg_aw-1:0] rd,
                           input logic [data_w-1:0] alu, sd);
        wb_rec_t           rec;
        logic [data_w-1:0] addr;
        int                n;
        addr = rf ? alu + data_w'(stack_step) : alu;   // Return address above SP
        rec.reg_write  = rw;
        rec.ret_future = rf;
        rec.mem_to_reg = m2r;
        rec.reg_rd     = rd;
        rec.alu        = c ? alu - data_w'(stack_step) : alu;
        rec.is_load    = mr && !mw;
        rec.rdata      = 'x;
        if (mw)
            model_mem[int'(addr[mem_aw:1])] = sd;
        else if (mr && model_mem.exists(int'(addr[mem_aw:1])))
            rec.rdata = model_mem[int'(addr[mem_aw:1])];
        exp_q.push_back(rec);
        ex_valid   = 1'b1;
        call       = c;
        ret_future = rf;
        reg_write  = rw;
        mem_write  = mw;
        mem_read   = mr;
        mem_to_reg = m2r;
        reg_rd     = rd;
        alu_result = alu;
        store_data = sd;
        n = 0;
        while (!ex_ready) begin
            @(posedge clk);
            #1;
            n++;
            if (n > wait_limit) report_timeout("execute operation never accepted");
        end
        @(posedge clk);   // Accepted at this edge
        #1;
        ex_valid = 1'b0;
    endtask

    // Load or store at word w of a region, random ret_future
    task automatic mem_access(input logic is_store, input logic [data_w-1:0] base, input int w);
        logic              rf;
        logic [data_w-1:0] addr;
        rf   = $urandom % 2;
        addr = base + data_w'(2 * w);
        send_op($urandom % 2, rf, $urandom % 2, is_store, !is_store, !is_store, $urandom % 16,
                rf ? addr - data_w'(stack_step) : addr, $urandom);
    endtask

    task automatic drain_wb();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > wait_limit) report_timeout("writeback results still missing");
        end
    endtask

    // Consumes count instructions with random instr_ready
    task automatic fetch_stream(input int count);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < count) begin
            @(posedge clk);
            #1;
            instr_ready = ($urandom % 4) != 0;
            if (instr_valid && instr_ready) begin
                check_val("instr_pc", instr_pc, exp_pc);
                check_val("instr", instr, model_mem[int'(exp_pc[mem_aw:1])]);
                exp_pc = exp_pc + data_w'(2);
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > wait_limit) report_timeout("fetch stream stalled");
            end
        end
        @(posedge clk);   // Last pop
        #1;
        instr_ready = 1'b0;
    endtask

    // Writeback monitor, outputs settled 1 ns after the edge
    always @(posedge clk) begin
        #1;
        if (arst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t: wb_valid with no operation outstanding", $time);
            end else begin
                mon_rec = exp_q.pop_front();
                check_val("wb_reg_write", wb_reg_write, mon_rec.reg_write);
                check_val("wb_ret_future", wb_ret_future, mon_rec.ret_future);
                check_val("wb_mem_to_reg", wb_mem_to_reg, mon_rec.mem_to_reg);
                check_val("wb_reg_rd", wb_reg_rd, mon_rec.reg_rd);
                check_val("wb_alu_result", wb_alu_result, mon_rec.alu);
                if (mon_rec.is_load)
                    check_val("wb_mem_read_data", wb_mem_read_data, mon_rec.rdata);
            end
        end
    end

    initial begin
        void'($urandom(32'hb195c614));
        arst_n = 1'b0;
        {ex_valid, call, ret_future, reg_write, mem_write, mem_read, mem_to_reg} = '0;
        reg_rd = '0;
        alu_result = '0;
        store_data = '0;
        {fetch_en, pc_load, instr_ready} = '0;
        pc_load_value = '0;
        repeat (2) @(posedge clk);
        #1;
        check_val("wb_valid in reset", wb_valid, 1'b0);
        check_val("instr_valid in reset", instr_valid, 1'b0);
        check_val("ex_ready in reset", ex_ready, 1'b1);
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;
        check_val("wb_valid after reset", wb_valid, 1'b0);
        check_val("instr_valid after reset", instr_valid, 1'b0);
        check_val("ex_ready after reset", ex_ready, 1'b1);

        // Non-memory pass-through with stack adjust
        repeat (30)
            send_op($urandom % 2, $urandom % 2, $urandom % 2, 1'b0, 1'b0, $urandom % 2,
                    $urandom % 16, $urandom, $urandom);
        drain_wb();

        // Fill both regions, then random stores and loads in region A
        for (int i = 0; i < a_words; i++)
            mem_access(1'b1, region_a, i);
        for (int i = 0; i < b_words; i++)
            mem_access(1'b1, region_b, i);
        repeat (24) mem_access(1'b1, region_a, $urandom % a_words);
        repeat (24) mem_access(1'b0, region_a, $urandom % a_words);
        drain_wb();

        // Fetch from region A with back-pressure
        pc_load       = 1'b1;
        pc_load_value = region_a;
        @(posedge clk);
        #1;
        pc_load  = 1'b0;
        fetch_en = 1'b1;
        exp_pc   = region_a;
        fetch_stream(24);

        // Both ports busy, data in region B
        fork
            fetch_stream(32);
            repeat (20) mem_access($urandom % 2, region_b, $urandom % b_words);
        join
        drain_wb();
        fetch_en = 1'b0;
        end_run();
    end

endmodule

// ==== mem_sys.f ====
hw/mem_sys_pkg.sv
hw/mem_req_if.sv
hw/mem_stage.sv
hw/fetch_unit.sv
hw/mem_arbiter.sv
hw/unified_mem.sv
hw/mem_sys_top.sv
verification/mem_sys_checker.sv
verification/mem_sys_tb.sv

// ==== Bender.yml ====
package:
  name: mem_sys

sources:
  - hw/mem_sys_pkg.sv
  - hw/mem_req_if.sv
  - hw/mem_stage.sv
  - hw/fetch_unit.sv
  - hw/mem_arbiter.sv
  - hw/unified_mem.sv
  - hw/mem_sys_top.sv
  - target: simulation
    files:
      - verification/mem_sys_checker.sv
      - verification/mem_sys_tb.sv
